// ==== flist.f ====
source/soc_bus_pkg.sv
source/soc_regs_pkg.sv
source/mem_bus_if.sv
source/bus_arbiter.sv
source/dbg_writer.sv
source/addr_decode.sv
source/misc_regs.sv
source/reload_seq.sv
source/scratch_ram.sv
source/soc_ctrl_top.sv
dv/soc_ctrl_checker.sv
dv/tb_soc_ctrl.sv

// ==== Makefile ====
# Verilator simulation of the SoC control core

VERILATOR ?= verilator
TOP       ?= tb_soc_ctrl
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== dv/tb_soc_ctrl.sv ====
/*
 * testbench for the SoC control core
 * drives the CPU bus and the debug port on the falling clock edge and keeps
 * a reference model of the registers, the scratch RAM and the reload sequencer
 */
`timescale 1ns/1ps
`default_nettype none

module tb_soc_ctrl;
	import soc_bus_pkg::*;
	import soc_regs_pkg::*;

	localparam int          genio_width = 30;
	localparam int          ram_words   = 256;
	localparam logic [31:0] soc_version = 32'h0001_0203;
	localparam int          bus_timeout = 50;
	localparam int          poll_limit  = 64;

	logic                   clk48m;
	logic                   rst;
	logic                   cpu_valid;
	logic [31:0]            cpu_addr;
	logic [31:0]            cpu_wdata;
	logic [3:0]             cpu_wstrb;
	logic [31:0]            cpu_rdata;
	logic                   cpu_ready;
	logic                   dbg_strobe;
	logic                   dbg_sel;
	logic [31:0]            dbg_data;
	logic [7:0]             btn;
	logic [genio_width-1:0] genio_in;
	logic [15:0]            led;
	logic [genio_width-1:0] genio_out;
	logic [genio_width-1:0] genio_oe;
	logic                   fsel_c;
	logic                   fsel_d;
	logic                   programn;
	logic                   trace_en;
	logic [31:0]            irq;

	// reference model state
	logic [15:0]            led_m;
	logic [genio_width-1:0] genio_out_m;
	logic [genio_width-1:0] genio_oe_m;
	logic                   trace_en_m;
	logic                   fsel_d_m;
	logic                   reload_m;
	logic [31:0]            ram_m [ram_words];

	// expectations handed to the checker
	logic        xfer_chk;
	logic [31:0] exp_rdata;
	logic        exp_bus_err;
	logic        port_chk;
	logic        exp_fsel_c;
	logic        exp_programn;

	logic [31:0] lfsr;
	int          timeouts;
	int          error_count;
	int          check_count;

	always #50 clk48m = ~clk48m;

	soc_ctrl_top #(
		.GENIO_WIDTH   (genio_width),
		.DBG_FIFO_DEPTH(32),
		.RAM_WORDS     (ram_words),
		.SOC_VERSION   (soc_version)
	) soc_ctrl_top_i (
		.clk48m      (clk48m),
		.rst         (rst),
		.cpu_valid_i (cpu_valid),
		.cpu_addr_i  (cpu_addr),
		.cpu_wdata_i (cpu_wdata),
		.cpu_wstrb_i (cpu_wstrb),
		.cpu_rdata_o (cpu_rdata),
		.cpu_ready_o (cpu_ready),
		.dbg_strobe_i(dbg_strobe),
		.dbg_sel_i   (dbg_sel),
		.dbg_data_i  (dbg_data),
		.btn_i       (btn),
		.genio_in_i  (genio_in),
		.led_o       (led),
		.genio_out_o (genio_out),
		.genio_oe_o  (genio_oe),
		.fsel_c_o    (fsel_c),
		.fsel_d_o    (fsel_d),
		.programn_o  (programn),
		.trace_en_o  (trace_en),
		.irq_o       (irq)
	);

	soc_ctrl_checker #(
		.GENIO_WIDTH(genio_width)
	) u_checker (
		.clk48m         (clk48m),
		.rst            (rst),
		.cpu_valid_i    (cpu_valid),
		.cpu_ready_i    (cpu_ready),
		.cpu_rdata_i    (cpu_rdata),
		.irq_i          (irq),
		.led_i          (led),
		.genio_out_i    (genio_out),
		.genio_oe_i     (genio_oe),
		.trace_en_i     (trace_en),
		.fsel_d_i       (fsel_d),
		.fsel_c_i       (fsel_c),
		.programn_i     (programn),
		.xfer_chk_i     (xfer_chk),
		.exp_rdata_i    (exp_rdata),
		.exp_bus_err_i  (exp_bus_err),
		.port_chk_i     (port_chk),
		.exp_led_i      (led_m),
		.exp_genio_out_i(genio_out_m),
		.exp_genio_oe_i (genio_oe_m),
		.exp_trace_en_i (trace_en_m),
		.exp_fsel_d_i   (fsel_d_m),
		.exp_fsel_c_i   (exp_fsel_c),
		.exp_programn_i (exp_programn),
		.error_count_o  (error_count),
		.check_count_o  (check_count)
	);

	// ----------------------------------------
	// random numbers
	// ----------------------------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		// x^32 + x^22 + x^2 + x + 1
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// ----------------------------------------
	// reference model
	// ----------------------------------------
	function automatic logic [31:0] reg_addr(input logic [4:0] idx);
		return {region_misc, 21'b0, idx, 2'b00};
	endfunction

	function automatic logic ref_bus_err(input logic [31:0] addr);
		return !(addr[31:28] == region_misc || addr[31:28] == region_ram);
	endfunction

	function automatic logic [31:0] ref_read(input logic [31:0] addr);
		logic [31:0] r;
		r = '0;
		if (addr[31:28] == region_ram) begin
			r = ram_m[addr[9:2]];
		end else if (addr[31:28] == region_misc) begin
			case (addr[6:2])
				reg_led:       r[15:0] = led_m;
				reg_btn:       r[7:0] = ~btn;
				reg_soc_ver:   r = soc_version;
				// the CPU is the master that is served
				reg_cpu_no:    r[0] = 1'b0;
				reg_flash_sel: r[0] = fsel_d_m;
				reg_genio_in:  r[genio_width-1:0] = genio_in;
				reg_genio_out: r[genio_width-1:0] = genio_out_m;
				reg_genio_oe:  r[genio_width-1:0] = genio_oe_m;
				default:       r = '0;
			endcase
		end else begin
			r = 32'hdead_beef;
		end
		return r;
	endfunction

	// fsel_c and programn during cycle k after the flash-select write
	function automatic logic ref_fsel_c(input int k);
		return k >= 3 && k <= 5;
	endfunction

	function automatic logic ref_programn(input int k);
		return !(reload_m && k >= 8);
	endfunction

	task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		if (addr[31:28] == region_ram) begin
			for (int b = 0; b < 4; b++) begin
				if (strb[b])
					ram_m[addr[9:2]][8*b +: 8] = data[8*b +: 8];
			end
		end else if (addr[31:28] == region_misc) begin
			case (addr[6:2])
				reg_led:       led_m = data[15:0];
				reg_soc_ver:   trace_en_m = data[0];
				reg_genio_out: genio_out_m = data[genio_width-1:0];
				reg_genio_oe:  genio_oe_m = data[genio_width-1:0];
				reg_genio_w2s: genio_out_m = genio_out_m | data[genio_width-1:0];
				reg_genio_w2c: genio_out_m = genio_out_m & ~data[genio_width-1:0];
				reg_flash_sel: begin
					fsel_d_m = data[0];
					if (data[31:8] == 24'hd0f1a5)
						reload_m = 1'b1;
				end
				default: ;
			endcase
		end
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	task automatic cpu_access(input logic [31:0] addr, input logic [31:0] wdata,
			input logic [3:0] strb, input logic check, output logic [31:0] rdata);
		logic done;
		done = 1'b0;
		rdata = '0;
		@(negedge clk48m);
		cpu_valid = 1'b1;
		cpu_addr = addr;
		cpu_wdata = wdata;
		cpu_wstrb = strb;
		exp_rdata = ref_read(addr);
		exp_bus_err = ref_bus_err(addr);
		xfer_chk = check && (strb == 4'h0);
		for (int n = 0; n < bus_timeout && !done; n++) begin
			@(posedge clk48m);
			if (cpu_ready) begin
				done = 1'b1;
				rdata = cpu_rdata;
			end
		end
		@(negedge clk48m);
		cpu_valid = 1'b0;
		cpu_wstrb = 4'h0;
		xfer_chk = 1'b0;
		exp_bus_err = 1'b0;
		if (!done) begin
			$display("timeout at time %0t: no ready on the CPU bus for address %h", $time, addr);
			timeouts++;
		end else if (strb != 4'h0) begin
			model_write(addr, wdata, strb);
		end
	endtask

	task automatic push_dbg_word(input logic sel, input logic [31:0] data);
		@(negedge clk48m);
		dbg_strobe = 1'b1;
		dbg_sel = sel;
		dbg_data = data;
		@(negedge clk48m);
		dbg_strobe = 1'b0;
	endtask

	task automatic reg_tests();
		logic [31:0] v;
		logic [31:0] rd;
		take_bits(16, v);
		cpu_access(reg_addr(reg_led), v, 4'hf, 1'b0, rd);
		cpu_access(reg_addr(reg_led), '0, 4'h0, 1'b1, rd);
		take_bits(30, v);
		cpu_access(reg_addr(reg_genio_out), v, 4'hf, 1'b0, rd);
		cpu_access(reg_addr(reg_genio_out), '0, 4'h0, 1'b1, rd);
		take_bits(30, v);
		cpu_access(reg_addr(reg_genio_oe), v, 4'hf, 1'b0, rd);
		cpu_access(reg_addr(reg_genio_oe), '0, 4'h0, 1'b1, rd);
		// set then clear on top of the current output value
		take_bits(30, v);
		cpu_access(reg_addr(reg_genio_w2s), v, 4'hf, 1'b0, rd);
		cpu_access(reg_addr(reg_genio_out), '0, 4'h0, 1'b1, rd);
		take_bits(30, v);
		cpu_access(reg_addr(reg_genio_w2c), v, 4'hf, 1'b0, rd);
		cpu_access(reg_addr(reg_genio_out), '0, 4'h0, 1'b1, rd);
		cpu_access(reg_addr(reg_btn), '0, 4'h0, 1'b1, rd);
		cpu_access(reg_addr(reg_genio_in), '0, 4'h0, 1'b1, rd);
		cpu_access(reg_addr(reg_soc_ver), '0, 4'h0, 1'b1, rd);
		cpu_access(reg_addr(reg_soc_ver), 32'h1, 4'hf, 1'b0, rd);
		cpu_access(reg_addr(reg_cpu_no), '0, 4'h0, 1'b1, rd);
		cpu_access(reg_addr(reg_flash_sel), '0, 4'h0, 1'b1, rd);
		cpu_access(reg_addr(5'd7), '0, 4'h0, 1'b1, rd);
	endtask

	task automatic ram_tests();
		logic [31:0] idx;
		logic [31:0] data;
		logic [31:0] strb;
		logic [31:0] rd;
		// full words first so that every byte is known
		for (int i = 0; i < 16; i++) begin
			take_bits(32, data);
			cpu_access(32'h4000_0000 + 32'(i * 4), data, 4'hf, 1'b0, rd);
		end
		for (int i = 0; i < 32; i++) begin
			take_bits(4, idx);
			take_bits(32, data);
			take_bits(4, strb);
			if (strb[3:0] == 4'h0)
				strb = 32'hf;
			cpu_access(32'h4000_0000 | (idx << 2), data, strb[3:0], 1'b0, rd);
		end
		for (int i = 0; i < 16; i++)
			cpu_access(32'h4000_0000 + 32'(i * 4), '0, 4'h0, 1'b1, rd);
	endtask

	task automatic unmapped_tests();
		logic [31:0] rd;
		cpu_access(32'h7000_0010, '0, 4'h0, 1'b1, rd);
		cpu_access(32'hc000_0040, 32'h1234_5678, 4'hf, 1'b0, rd);
		cpu_access(32'h0000_0000, '0, 4'h0, 1'b1, rd);
	endtask

	task automatic debug_tests();
		logic [31:0] base;
		logic [31:0] data [8];
		logic [31:0] rd;
		int          polls;
		base = 32'h4000_0200;
		push_dbg_word(1'b1, base);
		for (int i = 0; i < 8; i++) begin
			take_bits(32, data[i]);
			data[i][0] = 1'b1;
			push_dbg_word(1'b0, data[i]);
		end
		// the debug writer is still draining its FIFO here
		cpu_access(reg_addr(reg_cpu_no), '0, 4'h0, 1'b1, rd);
		for (int i = 0; i < 8; i++)
			model_write(base + 32'(i * 4), data[i], 4'hf);
		// writes land in order, so the last word arriving means all did
		rd = ~data[7];
		polls = 0;
		while (rd != data[7] && polls < poll_limit) begin
			cpu_access(base + 32'd28, '0, 4'h0, 1'b0, rd);
			polls++;
		end
		if (rd != data[7]) begin
			$display("debug writes did not reach the scratch RAM in time");
			timeouts++;
		end
		for (int i = 0; i < 8; i++)
			cpu_access(base + 32'(i * 4), '0, 4'h0, 1'b1, rd);
	endtask

	task automatic fsel_test(input logic keyed);
		logic [31:0] data;
		logic [31:0] rd;
		data = keyed ? {24'hd0f1a5, 8'h00} : 32'h0000_0001;
		cpu_access(reg_addr(reg_flash_sel), data, 4'hf, 1'b0, rd);
		// back at the falling edge inside the first cycle after the write
		for (int k = 1; k <= 12; k++) begin
			exp_fsel_c = ref_fsel_c(k);
			exp_programn = ref_programn(k);
			@(negedge clk48m);
		end
		exp_fsel_c = 1'b0;
		exp_programn = !reload_m;
		cpu_access(reg_addr(reg_flash_sel), '0, 4'h0, 1'b1, rd);
	endtask

	initial begin
		clk48m = 1'b0;
		rst = 1'b1;
		cpu_valid = 1'b0;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_wstrb = 4'h0;
		dbg_strobe = 1'b0;
		dbg_sel = 1'b0;
		dbg_data = '0;
		btn = 8'ha5;
		genio_in = 30'h2bad_f00d;
		led_m = '0;
		genio_out_m = '0;
		genio_oe_m = '0;
		trace_en_m = 1'b0;
		fsel_d_m = 1'b0;
		reload_m = 1'b0;
		xfer_chk = 1'b0;
		exp_rdata = '0;
		exp_bus_err = 1'b0;
		port_chk = 1'b0;
		exp_fsel_c = 1'b0;
		exp_programn = 1'b1;
		lfsr = 32'hb904_2de6;
		timeouts = 0;

		repeat (16) @(negedge clk48m);
		rst = 1'b0;
		// reset values are compared from the first cycle on
		port_chk = 1'b1;

		reg_tests();
		ram_tests();
		unmapped_tests();
		debug_tests();
		fsel_test(1'b0);
		fsel_test(1'b1);

		repeat (2) @(negedge clk48m);
		$display("checks: %0d  errors: %0d  timeouts: %0d", check_count, error_count, timeouts);
		if (error_count == 0 && timeouts == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== dv/soc_ctrl_checker.sv ====
/*
 * testbench checker for the SoC control core
 * watches the DUT ports on the rising clock and compares them with the
 * values that the testbench derives from its reference model
 */
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl_checker #(
	parameter int GENIO_WIDTH = 30
) (
	input  wire logic                   clk48m,
	input  wire logic                   rst,
	input  wire logic                   cpu_valid_i,
	input  wire logic                   cpu_ready_i,
	input  wire logic [31:0]            cpu_rdata_i,
	input  wire logic [31:0]            irq_i,
	input  wire logic [15:0]            led_i,
	input  wire logic [GENIO_WIDTH-1:0] genio_out_i,
	input  wire logic [GENIO_WIDTH-1:0] genio_oe_i,
	input  wire logic                   trace_en_i,
	input  wire logic                   fsel_d_i,
	input  wire logic                   fsel_c_i,
	input  wire logic                   programn_i,
	input  wire logic                   xfer_chk_i,
	input  wire logic [31:0]            exp_rdata_i,
	input  wire logic                   exp_bus_err_i,
	input  wire logic                   port_chk_i,
	input  wire logic [15:0]            exp_led_i,
	input  wire logic [GENIO_WIDTH-1:0] exp_genio_out_i,
	input  wire logic [GENIO_WIDTH-1:0] exp_genio_oe_i,
	input  wire logic                   exp_trace_en_i,
	input  wire logic                   exp_fsel_d_i,
	input  wire logic                   exp_fsel_c_i,
	input  wire logic                   exp_programn_i,
	output int                          error_count_o,
	output int                          check_count_o
);

	logic        xfer;
	logic [31:0] irq_exp;

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count_o++;
		if (got !== exp) begin
			error_count_o++;
			$display("error at time %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	// values sampled here are the ones held through the cycle that just ended
	always @(posedge clk48m) begin
		if (rst) begin
			error_count_o = 0;
			check_count_o = 0;
		end else begin
			xfer = cpu_valid_i && cpu_ready_i;

			// bus error interrupt only in the ready cycle of an unmapped access
			irq_exp = '0;
			irq_exp[3] = xfer && exp_bus_err_i;
			compare("irq_o", irq_i, irq_exp);

			if (xfer && xfer_chk_i)
				compare("cpu_rdata_o", cpu_rdata_i, exp_rdata_i);

			// ----------------------------------------
			// register outputs, between CPU accesses
			// ----------------------------------------
			if (port_chk_i && !cpu_valid_i) begin
				compare("led_o", 32'(led_i), 32'(exp_led_i));
				compare("genio_out_o", 32'(genio_out_i), 32'(exp_genio_out_i));
				compare("genio_oe_o", 32'(genio_oe_i), 32'(exp_genio_oe_i));
				compare("trace_en_o", 32'(trace_en_i), 32'(exp_trace_en_i));
				compare("fsel_d_o", 32'(fsel_d_i), 32'(exp_fsel_d_i));
			end

			// sequencer outputs are checked every cycle
			compare("fsel_c_o", 32'(fsel_c_i), 32'(exp_fsel_c_i));
			compare("programn_o", 32'(programn_i), 32'(exp_programn_i));
		end
	end

endmodule

`default_nettype wire

// ==== source/soc_ctrl_top.sv ====
/*
 * SoC control core
 * CPU port and debug writer share one bus through the arbiter, the decoder
 * feeds the misc registers and the scratch RAM, reload sequencer on flash select
 */
`timescale 1ns/1ps
`default_nettype none

module soc_ctrl_top #(
	parameter int                                  GENIO_WIDTH    = 30,
	parameter int                                  DBG_FIFO_DEPTH = 32,
	parameter int                                  RAM_WORDS      = 256,
	parameter logic [soc_bus_pkg::data_width-1:0] SOC_VERSION    = 32'h0000_8000
) (
	input  wire logic                               clk48m,
	input  wire logic                               rst,
	input  wire logic                               cpu_valid_i,
	input  wire logic [soc_bus_pkg::addr_width-1:0] cpu_addr_i,
	input  wire logic [soc_bus_pkg::data_width-1:0] cpu_wdata_i,
	input  wire logic [soc_bus_pkg::strb_width-1:0] cpu_wstrb_i,
	output logic      [soc_bus_pkg::data_width-1:0] cpu_rdata_o,
	output logic                                    cpu_ready_o,
	input  wire logic                               dbg_strobe_i,
	input  wire logic                               dbg_sel_i,
	input  wire logic [soc_bus_pkg::data_width-1:0] dbg_data_i,
	input  wire logic [7:0]                         btn_i,
	input  wire logic [GENIO_WIDTH-1:0]             genio_in_i,
	output logic      [15:0]                        led_o,
	output logic      [GENIO_WIDTH-1:0]             genio_out_o,
	output logic      [GENIO_WIDTH-1:0]             genio_oe_o,
	output logic                                    fsel_c_o,
	output logic                                    fsel_d_o,
	output logic                                    programn_o,
	output logic                                    trace_en_o,
	output logic      [31:0]                        irq_o
);
	import soc_bus_pkg::*;

	mem_bus_if dbg_bus ();
	mem_bus_if arb_bus ();
	mem_bus_if misc_bus ();
	mem_bus_if ram_bus ();

	master_e curr_master;
	logic    fsel_write;
	logic    reload_arm;

	// ----------------------------------------
	// bus masters and arbitration
	// ----------------------------------------
	dbg_writer #(
		.DBG_FIFO_DEPTH(DBG_FIFO_DEPTH)
	) u_dbg_writer (
		.clk48m  (clk48m),
		.rst     (rst),
		.strobe_i(dbg_strobe_i),
		.sel_i   (dbg_sel_i),
		.data_i  (dbg_data_i),
		.bus     (dbg_bus.master)
	);

	bus_arbiter u_arbiter (
		.clk48m       (clk48m),
		.rst          (rst),
		.cpu_valid_i  (cpu_valid_i),
		.cpu_addr_i   (cpu_addr_i),
		.cpu_wdata_i  (cpu_wdata_i),
		.cpu_wstrb_i  (cpu_wstrb_i),
		.cpu_rdata_o  (cpu_rdata_o),
		.cpu_ready_o  (cpu_ready_o),
		.dbg_bus      (dbg_bus.slave),
		.shared       (arb_bus.master),
		.curr_master_o(curr_master)
	);

	addr_decode u_decode (
		.up   (arb_bus.slave),
		.misc (misc_bus.master),
		.ram  (ram_bus.master),
		.irq_o(irq_o)
	);

	// ----------------------------------------
	// targets
	// ----------------------------------------
	misc_regs #(
		.GENIO_WIDTH(GENIO_WIDTH),
		.SOC_VERSION(SOC_VERSION)
	) u_misc (
		.clk48m       (clk48m),
		.rst          (rst),
		.bus          (misc_bus.slave),
		.btn_i        (btn_i),
		.genio_in_i   (genio_in_i),
		.curr_master_i(curr_master),
		.led_o        (led_o),
		.genio_out_o  (genio_out_o),
		.genio_oe_o   (genio_oe_o),
		.trace_en_o   (trace_en_o),
		.fsel_d_o     (fsel_d_o),
		.fsel_write_o (fsel_write),
		.reload_arm_o (reload_arm)
	);

	reload_seq u_reload (
		.clk48m      (clk48m),
		.rst         (rst),
		.fsel_write_i(fsel_write),
		.reload_arm_i(reload_arm),
		.fsel_c_o    (fsel_c_o),
		.programn_o  (programn_o)
	);

	scratch_ram #(
		.RAM_WORDS(RAM_WORDS)
	) u_ram (
		.clk48m(clk48m),
		.rst   (rst),
		.bus   (ram_bus.slave)
	);

endmodule

`default_nettype wire

// ==== source/scratch_ram.sv ====
/*
 * scratch RAM
 * word array with byte strobes, answers one cycle after valid
 */
`timescale 1ns/1ps
`default_nettype none

module scratch_ram #(
	parameter int RAM_WORDS = 256
) (
	input  wire logic clk48m,
	input  wire logic rst,
	mem_bus_if.slave  bus
);
	import soc_bus_pkg::*;

	localparam int idx_w = $clog2(RAM_WORDS);

	logic [data_width-1:0] mem [RAM_WORDS];
	logic [idx_w-1:0]      idx;
	logic                  ready_q;
	logic [data_width-1:0] rdata_q;

	assign idx = bus.addr[idx_w+1:2];

	always_ff @(posedge clk48m) begin
		if (rst)
			ready_q <= 1'b0;
		else
			ready_q <= bus.valid && !ready_q;
	end

	// access happens once, in the first valid cycle
	always_ff @(posedge clk48m) begin
		if (bus.valid && !ready_q) begin
			rdata_q <= mem[idx];
			for (int b = 0; b < strb_width; b++) begin
				if (bus.wstrb[b])
					mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
			end
		end
	end

	assign bus.ready = ready_q;
	assign bus.rdata = rdata_q;

endmodule

`default_nettype wire

// ==== source/reload_seq.sv ====
/*
 * flash select and FPGA reload sequencer
 * clocks the flash-select flop after a short delay, then pulls PROGRAMN
 */
`timescale 1ns/1ps
`default_nettype none

module reload_seq (
	input  wire logic clk48m,
	input  wire logic rst,
	input  wire logic fsel_write_i,
	input  wire logic reload_arm_i,
	output logic      fsel_c_o,
	output logic      programn_o
);
	import soc_regs_pkg::*;

	logic [2:0] count_q;
	logic       queued_q;
	logic       reload_q;

	// give fsel_d time to settle before the clock edge
	assign fsel_c_o = (count_q <= fsel_c_hi) && (count_q >= fsel_c_lo);
	assign programn_o = ~reload_q;

	always_ff @(posedge clk48m) begin
		if (rst) begin
			count_q <= '0;
			queued_q <= 1'b0;
			reload_q <= 1'b0;
		end else if (fsel_write_i) begin
			count_q <= fsel_delay_start;
			if (reload_arm_i)
				queued_q <= 1'b1;
		end else if (count_q != '0) begin
			count_q <= count_q - 1'b1;
			// stays low until reset
			if (count_q == 3'd1 && queued_q)
				reload_q <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/misc_regs.sv ====
/*
 * misc register region
 * LEDs, buttons, SoC version, current master, general I/O and flash select
 */
`timescale 1ns/1ps
`default_nettype none

module misc_regs #(
	parameter int                                  GENIO_WIDTH = 30,
	parameter logic [soc_bus_pkg::data_width-1:0] SOC_VERSION = 32'h0000_8000
) (
	input  wire logic                    clk48m,
	input  wire logic                    rst,
	mem_bus_if.slave                     bus,
	input  wire logic [7:0]              btn_i,
	input  wire logic [GENIO_WIDTH-1:0]  genio_in_i,
	input  soc_bus_pkg::master_e         curr_master_i,
	output logic      [15:0]             led_o,
	output logic      [GENIO_WIDTH-1:0]  genio_out_o,
	output logic      [GENIO_WIDTH-1:0]  genio_oe_o,
	output logic                         trace_en_o,
	output logic                         fsel_d_o,
	output logic                         fsel_write_o,
	output logic                         reload_arm_o
);
	import soc_regs_pkg::*;

	logic                   ready_q;
	logic                   wr_en;
	logic [4:0]             idx;
	logic [GENIO_WIDTH-1:0] wr_genio;

	assign idx = bus.addr[6:2];
	assign wr_genio = bus.wdata[GENIO_WIDTH-1:0];

	// writes land on the edge that raises ready
	assign wr_en = bus.valid && !ready_q && (bus.wstrb != '0);

	always_ff @(posedge clk48m) begin
		if (rst)
			ready_q <= 1'b0;
		else
			ready_q <= bus.valid && !ready_q;
	end

	assign bus.ready = ready_q;

	// ----------------------------------------
	// register writes
	// ----------------------------------------
	always_ff @(posedge clk48m) begin
		if (rst) begin
			led_o <= '0;
			genio_out_o <= '0;
			genio_oe_o <= '0;
			trace_en_o <= 1'b0;
			fsel_d_o <= 1'b0;
			fsel_write_o <= 1'b0;
			reload_arm_o <= 1'b0;
		end else begin
			fsel_write_o <= 1'b0;
			reload_arm_o <= 1'b0;
			if (wr_en) begin
				case (idx)
					reg_led:       led_o <= bus.wdata[15:0];
					reg_soc_ver:   trace_en_o <= bus.wdata[0];
					reg_genio_out: genio_out_o <= wr_genio;
					reg_genio_oe:  genio_oe_o <= wr_genio;
					reg_genio_w2s: genio_out_o <= genio_out_o | wr_genio;
					reg_genio_w2c: genio_out_o <= genio_out_o & ~wr_genio;
					reg_flash_sel: begin
						fsel_d_o <= bus.wdata[0];
						fsel_write_o <= 1'b1;
						// key in the upper bits queues an FPGA reload
						reload_arm_o <= (bus.wdata[31:8] == reload_key);
					end
					default: ;
				endcase
			end
		end
	end

	// read mux, unlisted words read zero
	always_comb begin
		bus.rdata = '0;
		case (idx)
			reg_led:       bus.rdata[15:0] = led_o;
			reg_btn:       bus.rdata[7:0] = ~btn_i;
			reg_soc_ver:   bus.rdata = SOC_VERSION;
			reg_cpu_no:    bus.rdata[0] = curr_master_i;
			reg_flash_sel: bus.rdata[0] = fsel_d_o;
			reg_genio_in:  bus.rdata[GENIO_WIDTH-1:0] = genio_in_i;
			reg_genio_out: bus.rdata[GENIO_WIDTH-1:0] = genio_out_o;
			reg_genio_oe:  bus.rdata[GENIO_WIDTH-1:0] = genio_oe_o;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/addr_decode.sv ====
/*
 * address decoder on the top nibble
 * misc registers in region 2, scratch RAM in region 4, bus error elsewhere
 */
`timescale 1ns/1ps
`default_nettype none

module addr_decode (
	mem_bus_if.slave   up,
	mem_bus_if.master  misc,
	mem_bus_if.master  ram,
	output logic [31:0] irq_o
);
	import soc_bus_pkg::*;

	logic [$bits(region_e)-1:0] region;

	assign region = up.addr[addr_width-1 -: $bits(region_e)];

	// request fields go to both targets, only valid is steered
	assign misc.addr = up.addr;
	assign misc.wdata = up.wdata;
	assign misc.wstrb = up.wstrb;
	assign ram.addr = up.addr;
	assign ram.wdata = up.wdata;
	assign ram.wstrb = up.wstrb;

	always_comb begin
		misc.valid = 1'b0;
		ram.valid = 1'b0;
		irq_o = '0;
		case (region)
			region_misc: begin
				misc.valid = up.valid;
				up.rdata = misc.rdata;
				up.ready = misc.ready;
			end
			region_ram: begin
				ram.valid = up.valid;
				up.rdata = ram.rdata;
				up.ready = ram.ready;
			end
			default: begin
				// unmapped, answer at once and flag it
				up.rdata = bus_error_rdata;
				up.ready = up.valid;
				irq_o[irq_bus_error] = up.valid;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/dbg_writer.sv ====
/*
 * debug register write path
 * queues address and data words and turns them into full-word bus writes
 * with the address stepping by one word after each write
 */
`timescale 1ns/1ps
`default_nettype none

module dbg_writer #(
	parameter int DBG_FIFO_DEPTH = 32
) (
	input  wire logic                               clk48m,
	input  wire logic                               rst,
	input  wire logic                               strobe_i,
	input  wire logic                               sel_i,
	input  wire logic [soc_bus_pkg::data_width-1:0] data_i,
	mem_bus_if.master                               bus
);
	import soc_bus_pkg::*;

	localparam int ptr_w = $clog2(DBG_FIFO_DEPTH);

	// bit data_width marks an address word
	logic [data_width:0]   fifo [DBG_FIFO_DEPTH];
	logic [ptr_w-1:0]      wr_ptr;
	logic [ptr_w-1:0]      rd_ptr;
	logic [data_width:0]   head;
	logic [addr_width-1:0] addr_q;
	logic [data_width-1:0] wdata_q;
	logic                  valid_q;

	assign head = fifo[rd_ptr];

	// no back-pressure towards the debug port
	always_ff @(posedge clk48m) begin
		if (strobe_i)
			fifo[wr_ptr] <= {sel_i, data_i};
	end

	always_ff @(posedge clk48m) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			addr_q <= '0;
			valid_q <= 1'b0;
		end else begin
			if (strobe_i)
				wr_ptr <= wr_ptr + 1'b1;
			if (valid_q) begin
				// write in flight, step to the next word once it lands
				if (bus.ready) begin
					valid_q <= 1'b0;
					addr_q <= addr_q + 4;
				end
			end else if (rd_ptr != wr_ptr) begin
				if (head[data_width])
					addr_q <= head[addr_width-1:0];
				else
					valid_q <= 1'b1;
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	// write data is payload only
	always_ff @(posedge clk48m) begin
		if (!valid_q && rd_ptr != wr_ptr && !head[data_width])
			wdata_q <= head[data_width-1:0];
	end

	assign bus.valid = valid_q;
	assign bus.addr = addr_q;
	assign bus.wdata = wdata_q;
	assign bus.wstrb = '1;

endmodule

`default_nettype wire

// ==== source/bus_arbiter.sv ====
/*
 * two-master bus arbiter
 * grants the shared bus to the CPU port or the debug writer and holds
 * the grant until the slave answers with ready
 */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
	input  wire logic                                clk48m,
	input  wire logic                                rst,
	input  wire logic                                cpu_valid_i,
	input  wire logic [soc_bus_pkg::addr_width-1:0]  cpu_addr_i,
	input  wire logic [soc_bus_pkg::data_width-1:0]  cpu_wdata_i,
	input  wire logic [soc_bus_pkg::strb_width-1:0]  cpu_wstrb_i,
	output logic      [soc_bus_pkg::data_width-1:0]  cpu_rdata_o,
	output logic                                     cpu_ready_o,
	mem_bus_if.slave                                 dbg_bus,
	mem_bus_if.master                                shared,
	output soc_bus_pkg::master_e                     curr_master_o
);
	import soc_bus_pkg::*;

	logic    busy_q;
	master_e grant_q;
	master_e pick;
	master_e sel;

	// debug writer wins a tie
	always_comb begin
		pick = dbg_bus.valid ? master_dbg : master_cpu;
		sel = busy_q ? grant_q : pick;
	end

	assign curr_master_o = sel;

	// ----------------------------------------
	// request out, response back
	// ----------------------------------------
	always_comb begin
		if (sel == master_dbg) begin
			shared.valid = dbg_bus.valid;
			shared.addr = dbg_bus.addr;
			shared.wdata = dbg_bus.wdata;
			shared.wstrb = dbg_bus.wstrb;
		end else begin
			shared.valid = cpu_valid_i;
			shared.addr = cpu_addr_i;
			shared.wdata = cpu_wdata_i;
			shared.wstrb = cpu_wstrb_i;
		end
		dbg_bus.rdata = shared.rdata;
		cpu_rdata_o = shared.rdata;
		// the loser only ever sees ready low
		dbg_bus.ready = (sel == master_dbg) && shared.ready;
		cpu_ready_o = (sel == master_cpu) && shared.ready;
	end

	// lock the grant while the slave is still working
	always_ff @(posedge clk48m) begin
		if (rst) begin
			busy_q <= 1'b0;
			grant_q <= master_cpu;
		end else if (busy_q) begin
			if (shared.ready)
				busy_q <= 1'b0;
		end else if (shared.valid && !shared.ready) begin
			busy_q <= 1'b1;
			grant_q <= pick;
		end
	end

endmodule

`default_nettype wire

// ==== source/mem_bus_if.sv ====
/*
 * valid/ready memory bus
 * master holds valid and its fields until ready, nonzero wstrb is a write
 */
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;
	import soc_bus_pkg::*;

	logic                  valid;
	logic [addr_width-1:0] addr;
	logic [data_width-1:0] wdata;
	logic [strb_width-1:0] wstrb;
	logic [data_width-1:0] rdata;
	logic                  ready;

	modport master (
		output valid, addr, wdata, wstrb,
		input  rdata, ready
	);

	modport slave (
		input  valid, addr, wdata, wstrb,
		output rdata, ready
	);

endinterface

`default_nettype wire

// ==== source/soc_regs_pkg.sv ====
/*
 * misc register region definitions
 * word indices, the reload key and the flash-select sequencer counts
 */
`default_nettype none

package soc_regs_pkg;

	// word index, taken from address bits 6:2
	typedef enum logic [4:0] {
		reg_led       = 5'd0,
		reg_btn       = 5'd1,
		reg_soc_ver   = 5'd2,
		reg_cpu_no    = 5'd3,
		reg_flash_sel = 5'd13,
		reg_genio_in  = 5'd17,
		reg_genio_out = 5'd18,
		reg_genio_oe  = 5'd19,
		reg_genio_w2s = 5'd20,
		reg_genio_w2c = 5'd21
	} misc_reg_e;

	// ----------------------------------------
	// flash select and reload
	// ----------------------------------------
	// upper 24 bits of a flash-select write that arm the reload
	localparam logic [23:0] reload_key = 24'hd0f1a5;

	// count loaded on a flash-select write
	localparam logic [2:0] fsel_delay_start = 3'd7;

	// flash-select clock is high while the count is inside this window
	localparam logic [2:0] fsel_c_hi = 3'd5;
	localparam logic [2:0] fsel_c_lo = 3'd3;

endpackage

`default_nettype wire

// ==== source/soc_bus_pkg.sv ====
/*
 * shared bus definitions for the control core
 * widths, address regions, master numbers and the bus error response
 */
`default_nettype none

package soc_bus_pkg;

	// ----------------------------------------
	// bus widths
	// ----------------------------------------
	localparam int addr_width = 32;
	localparam int data_width = 32;
	localparam int strb_width = data_width / 8;

	// top address nibble, anything not listed is unmapped
	typedef enum logic [3:0] {
		region_misc = 4'h2,
		region_ram  = 4'h4
	} region_e;

	// bus masters behind the arbiter
	typedef enum logic {
		master_cpu = 1'b0,
		master_dbg = 1'b1
	} master_e;

	// answer to an access that hits no region
	localparam logic [data_width-1:0] bus_error_rdata = 32'hdead_beef;

	// interrupt line raised on a bus error
	localparam int irq_bus_error = 3;

endpackage

`default_nettype wire
